/* verilog/cart_pkg.sv */
package cart_pkg;

  //////////////////////////////////////////////////
  // Widths with a meaning
  //////////////////////////////////////////////////
  typedef logic [23:0] addr_t;  // Console or memory address
  typedef logic [23:0] mask_t;  // Address mask
  typedef logic [7:0]  feat_t;  // Feature enable bits

  // Mapper modes as loaded by the MCU
  typedef enum logic [2:0] {
    MAP_HIROM   = 3'd0,
    MAP_LOROM   = 3'd1,
    MAP_EXHIROM = 3'd2,  // 48 to 64 Mbit
    MAP_MENU    = 3'd7   // Menu ROM in upper memory
  } mapper_e;

  // Bit positions inside feat_t
  localparam int FEAT_DSPX   = 0;
  localparam int FEAT_ST0010 = 1;
  localparam int FEAT_SRTC   = 2;
  localparam int FEAT_MSU1   = 3;

  // Register select on the MCU port
  typedef enum logic [1:0] {
    CFG_MAPPER,
    CFG_FEAT,
    CFG_ROM_MASK,
    CFG_SRAM_MASK
  } cfg_sel_e;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////
  typedef struct packed {
    mapper_e mapper;
    feat_t   featurebits;
    mask_t   rom_mask;
    mask_t   saveram_mask;
  } cart_cfg_t;

  typedef struct packed {
    addr_t addr;
    logic  cs_n;   // Cart select, active low
    logic  wr_n;   // Write strobe, active low
  } snes_bus_t;

  typedef struct packed {
    addr_t mem_addr;
    logic  is_rom;
    logic  is_saveram;
    logic  is_writable;
  } decode_t;

  typedef struct packed {
    addr_t addr;
    logic  write;
  } mem_cmd_t;

endpackage

/* verilog/cart_config.sv */
module cart_config (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                cfg_req,
  input  cart_pkg::cfg_sel_e  cfg_sel,
  input  cart_pkg::addr_t     cfg_data,
  output logic                cfg_ack,
  output cart_pkg::cart_cfg_t cfg
);
  import cart_pkg::*;

  typedef enum logic {
    CFG_IDLE,
    CFG_ACKED
  } cfg_state_e;

  cfg_state_e state;
  cfg_state_e state_nxt;
  logic       cfg_wr;

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      CFG_IDLE: begin
        if (cfg_req) begin
          state_nxt = CFG_ACKED;  // Write and ack together
        end
      end
      CFG_ACKED: begin
        if (!cfg_req) begin
          state_nxt = CFG_IDLE;   // MCU done, release ack
        end
      end
      default: state_nxt = CFG_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= CFG_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign cfg_wr  = (state == CFG_IDLE) && cfg_req;  // One write per handshake
  assign cfg_ack = (state == CFG_ACKED);

  //////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;  // HiROM, no features, masks zero
    end else if (cfg_wr) begin
      case (cfg_sel)
        CFG_MAPPER:    cfg.mapper       <= mapper_e'(cfg_data[2:0]);
        CFG_FEAT:      cfg.featurebits  <= cfg_data[7:0];
        CFG_ROM_MASK:  cfg.rom_mask     <= cfg_data;
        CFG_SRAM_MASK: cfg.saveram_mask <= cfg_data;
        default:       cfg.mapper       <= cfg.mapper;
      endcase
    end
  end

  // MCU keeps the select steady for the whole request phase
  a_sel_held: assert property (
    @(posedge CLK) disable iff (!rst_n)
    cfg_req && $past(cfg_req) |-> $stable(cfg_sel)
  ) else $error("cfg_sel changed while cfg_req high");

endmodule

/* verilog/address_map.sv */
module address_map (
  input  cart_pkg::addr_t     bus_addr,
  input  cart_pkg::cart_cfg_t cfg,
  output cart_pkg::decode_t   dec,
  output logic                dspx_sel_raw,
  output logic                dspx_dp_enable,
  output logic                srtc_enable,
  output logic                msu_sel_raw,
  output logic                dspx_a0
);
  import cart_pkg::*;

  addr_t       a;            // Short alias of the console address
  feat_t       feat;
  mapper_e     mapper;
  logic        hirom_type;   // Save RAM at 6000-7fff
  logic        sram_hi;
  logic        sram_lo;
  logic        sram_st;
  logic        is_saveram;
  logic [14:0] sram_off;
  addr_t       sram_base;
  addr_t       sram_addr;
  addr_t       rom_addr;

  assign a      = bus_addr;
  assign feat   = cfg.featurebits;
  assign mapper = cfg.mapper;

  assign hirom_type = (mapper == MAP_HIROM) || (mapper == MAP_EXHIROM) ||
                      (mapper == MAP_MENU);

  //////////////////////////////////////////////////
  // Save RAM windows
  //////////////////////////////////////////////////
  // Banks 30-3f and b0-bf, 6000-7fff
  assign sram_hi = ~a[22] & (&a[21:20]) & ~a[15] & (&a[14:13]);
  // Banks 70-7d and f0-fd, 0000-7fff
  assign sram_lo = (&a[22:20]) & (a[19:16] < 4'he) & ~a[15];
  // ST0010 banks 68-6f, 0800-0fff
  assign sram_st = (a[22:19] == 4'b1101) & (a[15:12] == 4'h0) & a[11];

  // Zero save RAM mask means no save RAM at all
  assign is_saveram = cfg.saveram_mask[0] &
                      (feat[FEAT_ST0010] ? sram_st :
                       hirom_type          ? sram_hi :
                       (mapper == MAP_LOROM) ? sram_lo : 1'b0);

  //////////////////////////////////////////////////
  // Memory address
  //////////////////////////////////////////////////
  assign sram_off  = hirom_type ? (a[14:0] - 15'h6000) : a[14:0];  // Wraps in 15 bits
  assign sram_base = (mapper == MAP_MENU) ? 24'hFF0000 : 24'hE00000;
  assign sram_addr = sram_base + ({9'd0, sram_off} & cfg.saveram_mask);

  always_comb begin
    case (mapper)
      MAP_HIROM:   rom_addr = {1'b0, a[22:0]} & cfg.rom_mask;
      MAP_LOROM:   rom_addr = {2'b00, a[22:16], a[14:0]} & cfg.rom_mask;  // Drop A15
      MAP_EXHIROM: rom_addr = {1'b0, ~a[23], a[21:0]} & cfg.rom_mask;     // Upper half first
      MAP_MENU:    rom_addr = ({1'b0, a[22:0]} & cfg.rom_mask) + 24'hE00000;
      default:     rom_addr = '0;
    endcase
  end

  assign dec.mem_addr    = is_saveram ? sram_addr : rom_addr;
  assign dec.is_rom      = a[22] | a[15];
  assign dec.is_saveram  = is_saveram;
  assign dec.is_writable = is_saveram;  // Only save RAM takes writes

  //////////////////////////////////////////////////
  // Coprocessor windows
  //////////////////////////////////////////////////
  // MSU registers at 2000-2007 in system banks
  assign msu_sel_raw = feat[FEAT_MSU1] & ~a[22] & (a[15:3] == 13'h0400);
  // RTC at 2800-2801
  assign srtc_enable = feat[FEAT_SRTC] & ~a[22] & (a[15:1] == 15'h1400);

  always_comb begin
    dspx_sel_raw = 1'b0;
    if (feat[FEAT_DSPX]) begin
      if (mapper == MAP_LOROM) begin
        if (cfg.rom_mask[20]) begin
          dspx_sel_raw = a[22] & a[21] & ~a[20] & ~a[15];   // 60-6f:0000-7fff
        end else begin
          dspx_sel_raw = ~a[22] & a[21] & a[20] & a[15];    // 30-3f:8000-ffff
        end
      end else if (mapper == MAP_HIROM) begin
        dspx_sel_raw = ~a[22] & ~a[21] & ~a[20] & ~a[15] & (&a[14:13]);  // 00-0f:6000-7fff
      end
    end else if (feat[FEAT_ST0010]) begin
      dspx_sel_raw = a[22] & a[21] & ~a[20] & (a[19:16] == 4'h0) & ~a[15];  // Bank 60
    end
  end

  // ST0010 data port at 68-6f:0000-07ff
  assign dspx_dp_enable = feat[FEAT_ST0010] & (a[22:19] == 4'b1101) & (a[15:11] == 5'd0);

  always_comb begin
    dspx_a0 = 1'b1;  // Idle high
    if (feat[FEAT_DSPX]) begin
      if (mapper == MAP_LOROM) begin
        dspx_a0 = a[14];
      end else if (mapper == MAP_HIROM) begin
        dspx_a0 = a[12];
      end
    end else if (feat[FEAT_ST0010]) begin
      dspx_a0 = a[0];
    end
  end

endmodule

/* verilog/select_filter.sv */
module select_filter #(
  parameter int FILTER_DEPTH = 4  // Samples that must all be high
) (
  input  logic CLK,
  input  logic rst_n,
  input  logic raw,
  output logic filtered
);

  //////////////////////////////////////////////////
  // Sample history
  //////////////////////////////////////////////////
  // Two newest samples are lead-in only
  logic [FILTER_DEPTH+1:0] hist;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      hist <= '0;
    end else begin
      hist <= {hist[FILTER_DEPTH:0], raw};  // Newest at bit 0
    end
  end

  // High only after a settled window
  assign filtered = &hist[FILTER_DEPTH+1:2];

endmodule

/* verilog/mem_request.sv */
module mem_request (
  input  logic                CLK,
  input  logic                rst_n,
  input  cart_pkg::snes_bus_t bus,
  input  cart_pkg::decode_t   dec,
  input  logic                mem_ack,
  output logic                mem_req,
  output cart_pkg::mem_cmd_t  mem_cmd
);

  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_HOLD,     // Request out, waiting for ack
    REQ_RELEASE   // Request dropped, waiting for ack low
  } req_state_e;

  req_state_e state;
  req_state_e state_nxt;
  logic [1:0] cs_hist;   // Bit 0 newest
  logic       cs_fall;
  logic       start;

  //////////////////////////////////////////////////
  // Bus cycle detect
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cs_hist <= 2'b11;  // Bus idle
    end else begin
      cs_hist <= {cs_hist[0], bus.cs_n};
    end
  end

  assign cs_fall = cs_hist[1] & ~cs_hist[0];
  // Falls during an open transfer are dropped
  assign start = (state == REQ_IDLE) && cs_fall && (dec.is_rom || dec.is_saveram);

  //////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      REQ_IDLE: begin
        if (start) begin
          state_nxt = REQ_HOLD;
        end
      end
      REQ_HOLD: begin
        if (mem_ack) begin
          state_nxt = REQ_RELEASE;
        end
      end
      REQ_RELEASE: begin
        if (!mem_ack) begin
          state_nxt = REQ_IDLE;  // Handshake closed
        end
      end
      default: state_nxt = REQ_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state   <= REQ_IDLE;
      mem_req <= 1'b0;
    end else begin
      state   <= state_nxt;
      mem_req <= (state == REQ_HOLD) && !mem_ack;  // One edge after command latch
    end
  end

  // Command captured once per transfer
  always_ff @(posedge CLK) begin
    if (start) begin
      mem_cmd.addr  <= dec.mem_addr;
      mem_cmd.write <= ~bus.wr_n & dec.is_writable;
    end
  end

  a_cmd_stable: assert property (
    @(posedge CLK) disable iff (!rst_n)
    mem_req && $past(mem_req) |-> $stable(mem_cmd)
  ) else $error("mem_cmd changed while mem_req high");

  // Previous handshake must be fully closed
  a_req_after_ack: assert property (
    @(posedge CLK) disable iff (!rst_n)
    $rose(mem_req) |-> !mem_ack
  ) else $error("mem_req rose while mem_ack high");

endmodule

/* verilog/cart_top.sv */
module cart_top #(
  parameter int FILTER_DEPTH = 4
) (
  input  logic                CLK,
  input  logic                rst_n,
  // MCU config port
  input  logic                cfg_req,
  input  cart_pkg::cfg_sel_e  cfg_sel,
  input  cart_pkg::addr_t     cfg_data,
  output logic                cfg_ack,
  // Console bus
  input  cart_pkg::snes_bus_t bus,
  // Memory controller
  output logic                mem_req,
  output cart_pkg::mem_cmd_t  mem_cmd,
  input  logic                mem_ack,
  // Region and coprocessor outputs
  output logic                is_rom,
  output logic                is_saveram,
  output logic                dspx_enable,
  output logic                dspx_dp_enable,
  output logic                dspx_a0,
  output logic                srtc_enable,
  output logic                msu_enable
);
  import cart_pkg::*;

  cart_cfg_t cfg;
  decode_t   dec;
  logic      dspx_sel_raw;
  logic      msu_sel_raw;

  //////////////////////////////////////////////////
  // Config and decode
  //////////////////////////////////////////////////
  cart_config u_config (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cfg_req  (cfg_req),
    .cfg_sel  (cfg_sel),
    .cfg_data (cfg_data),
    .cfg_ack  (cfg_ack),
    .cfg      (cfg)
  );

  address_map u_address_map (
    .bus_addr       (bus.addr),
    .cfg            (cfg),
    .dec            (dec),
    .dspx_sel_raw   (dspx_sel_raw),
    .dspx_dp_enable (dspx_dp_enable),  // Unfiltered
    .srtc_enable    (srtc_enable),     // Unfiltered
    .msu_sel_raw    (msu_sel_raw),
    .dspx_a0        (dspx_a0)
  );

  assign is_rom     = dec.is_rom;
  assign is_saveram = dec.is_saveram;

  //////////////////////////////////////////////////
  // Select filters and memory requests
  //////////////////////////////////////////////////
  select_filter #(.FILTER_DEPTH(FILTER_DEPTH)) u_dspx_filter (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .raw      (dspx_sel_raw),
    .filtered (dspx_enable)
  );

  select_filter #(.FILTER_DEPTH(FILTER_DEPTH)) u_msu_filter (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .raw      (msu_sel_raw),
    .filtered (msu_enable)
  );

  mem_request u_mem_request (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .bus     (bus),
    .dec     (dec),
    .mem_ack (mem_ack),
    .mem_req (mem_req),
    .mem_cmd (mem_cmd)
  );

endmodule

/* verif/cart_model.svh */
`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

// Expected coprocessor selects for one address
typedef struct packed {
  logic dspx;  // Raw DSP select, before filtering
  logic dp;    // ST0010 data port
  logic srtc;
  logic msu;   // Raw MSU select, before filtering
  logic a0;
} sel_t;

//////////////////////////////////////////////////
// Region and memory address
//////////////////////////////////////////////////
function automatic logic model_saveram(addr_t a, cart_cfg_t c);
  logic [7:0]  bank;
  logic [15:0] off;
  logic        hit;
  bank = a[23:16] & 8'h7f;  // Upper banks mirror lower ones
  off  = a[15:0];
  if (c.featurebits[FEAT_ST0010]) begin
    hit = bank >= 8'h68 && bank <= 8'h6f && off >= 16'h0800 && off <= 16'h0fff;
  end else if (c.mapper == MAP_LOROM) begin
    hit = bank >= 8'h70 && bank <= 8'h7d && !off[15];
  end else begin
    hit = bank >= 8'h30 && bank <= 8'h3f && off >= 16'h6000 && off <= 16'h7fff;
  end
  return hit && c.saveram_mask[0];  // Mask bit 0 clear means no save RAM
endfunction

function automatic decode_t model_decode(addr_t a, cart_cfg_t c);
  decode_t     d;
  logic [14:0] off15;
  d.is_saveram  = model_saveram(a, c);
  d.is_writable = d.is_saveram;
  d.is_rom      = a[22] || a[15];
  if (d.is_saveram) begin
    off15 = a[14:0];
    if (c.mapper != MAP_LOROM) off15 = off15 - 15'h6000;  // HiROM window starts at 6000
    d.mem_addr = ((c.mapper == MAP_MENU) ? 24'hff0000 : 24'he00000) +
                 (24'(off15) & c.saveram_mask);
  end else begin
    case (c.mapper)
      MAP_LOROM:   d.mem_addr = ((24'(a[22:16]) << 15) | 24'(a[14:0])) & c.rom_mask;
      MAP_EXHIROM: d.mem_addr = ((a & 24'h3fffff) | (a[23] ? 24'h0 : 24'h400000)) & c.rom_mask;
      MAP_MENU:    d.mem_addr = 24'he00000 + (a & 24'h7fffff & c.rom_mask);
      default:     d.mem_addr = a & 24'h7fffff & c.rom_mask;
    endcase
  end
  return d;
endfunction

//////////////////////////////////////////////////
// Coprocessor windows
//////////////////////////////////////////////////
function automatic sel_t model_selects(addr_t a, cart_cfg_t c);
  logic [7:0]  bank;
  logic [15:0] off;
  sel_t        s;
  bank = a[23:16] & 8'h7f;
  off  = a[15:0];
  s    = '0;
  s.a0 = 1'b1;  // A0 rests high with no DSP
  if (c.featurebits[FEAT_DSPX]) begin
    if (c.mapper == MAP_LOROM) begin
      s.a0 = a[14];
      if (c.rom_mask[20]) s.dspx = bank >= 8'h60 && bank <= 8'h6f && !off[15];  // Large ROM
      else                s.dspx = bank >= 8'h30 && bank <= 8'h3f && off[15];
    end else if (c.mapper == MAP_HIROM) begin
      s.a0   = a[12];
      s.dspx = bank <= 8'h0f && off >= 16'h6000 && off <= 16'h7fff;
    end
  end else if (c.featurebits[FEAT_ST0010]) begin
    s.a0   = a[0];
    s.dspx = bank == 8'h60 && !off[15];
  end
  s.dp   = c.featurebits[FEAT_ST0010] && bank >= 8'h68 && bank <= 8'h6f && off < 16'h0800;
  s.srtc = c.featurebits[FEAT_SRTC] && bank < 8'h40 && (off == 16'h2800 || off == 16'h2801);
  s.msu  = c.featurebits[FEAT_MSU1] && bank < 8'h40 && off >= 16'h2000 && off <= 16'h2007;
  return s;
endfunction

`endif

/* verif/cart_tb.sv */
module cart_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cart_pkg::*;

  `include "cart_model.svh"

  localparam int RESET_CYCLES = 16;
  localparam int CFG_BUDGET   = 10;   // Cycles per config write
  localparam int BUS_BUDGET   = 40;   // Cycles per bus cycle or filter run
  localparam int ITERS        = 150;  // Runs per mapper
  localparam int EARLY_RUNS   = 10;   // Bus cycles on the reset config
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + EARLY_RUNS * BUS_BUDGET +
                                  4 * (4 * CFG_BUDGET + ITERS * BUS_BUDGET) + 500;

  logic      CLK;
  logic      rst_n;
  logic      cfg_req;
  cfg_sel_e  cfg_sel;
  addr_t     cfg_data;
  logic      cfg_ack;
  snes_bus_t bus;
  logic      mem_req;
  mem_cmd_t  mem_cmd;
  logic      mem_ack;
  logic      is_rom;
  logic      is_saveram;
  logic      dspx_enable;
  logic      dspx_dp_enable;
  logic      dspx_a0;
  logic      srtc_enable;
  logic      msu_enable;

  cart_cfg_t  shadow = '0;     // What the MCU has written so far
  logic [5:0] dspx_hist = '0;  // Bit 0 is the newest raw sample
  logic [5:0] msu_hist = '0;
  mem_cmd_t   cmd_q[$];        // Commands seen by the responder
  int         errors = 0;
  int         checks = 0;
  int         req_count = 0;
  int         done_count = 0;
  int         cycle_count = 0;
  mapper_e    map_list[4] = '{MAP_HIROM, MAP_LOROM, MAP_EXHIROM, MAP_MENU};

  cart_top #(.FILTER_DEPTH(4)) dut (
    .CLK(CLK), .rst_n(rst_n),
    .cfg_req(cfg_req), .cfg_sel(cfg_sel), .cfg_data(cfg_data), .cfg_ack(cfg_ack),
    .bus(bus), .mem_req(mem_req), .mem_cmd(mem_cmd), .mem_ack(mem_ack),
    .is_rom(is_rom), .is_saveram(is_saveram), .dspx_enable(dspx_enable),
    .dspx_dp_enable(dspx_dp_enable), .dspx_a0(dspx_a0),
    .srtc_enable(srtc_enable), .msu_enable(msu_enable)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic compare(string name, logic [23:0] got, logic [23:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error: %s is %h, expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  // Addresses biased toward the interesting windows
  function automatic addr_t pick_address();
    logic [7:0]  bank;
    logic [15:0] off;
    bank = 8'($urandom);
    off  = 16'($urandom);
    case ($urandom_range(7, 0))
      0: ;                                                  // Anywhere
      1: begin bank[6:4] = 3'b011; off[15:13] = 3'b011; end // HiROM save RAM
      2: begin bank[6:4] = 3'b111; off[15] = 1'b0; end      // LoROM save RAM
      3: begin bank[6:3] = 4'b1101; off[15:12] = 4'h0; end  // ST0010 banks
      4: begin bank[6] = 1'b0; off[15:3] = 13'h0400; end    // MSU registers
      5: begin bank[6] = 1'b0; off[15:2] = 14'h0a00; end    // RTC and neighbours
      6: begin
        case ($urandom_range(3, 0))
          0: begin bank[6:4] = 3'b000; off[15:13] = 3'b011; end
          1: begin bank[6:4] = 3'b011; off[15] = 1'b1; end
          2: begin bank[6:4] = 3'b110; off[15] = 1'b0; end
          default: begin bank[6:0] = 7'h60; off[15] = 1'b0; end
        endcase
      end
      default: begin bank[6] = 1'b0; off[15] = 1'b0; end    // Mostly unmapped
    endcase
    return {bank, off};
  endfunction

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////
  task automatic write_config(cfg_sel_e sel, addr_t data);
    int waited;
    @(posedge CLK); #1;
    compare("cfg_ack", cfg_ack, 1'b0);  // Port idle before req
    cfg_sel  = sel;
    cfg_data = data;
    cfg_req  = 1'b1;
    waited   = 0;
    do begin
      @(posedge CLK); #1;
      waited++;
    end while (!cfg_ack && waited < CFG_BUDGET);
    assert (cfg_ack) else begin
      errors++;
      $display("Config write to %s was never acknowledged", sel.name());
    end
    case (sel)
      CFG_MAPPER:   shadow.mapper       = mapper_e'(data[2:0]);
      CFG_FEAT:     shadow.featurebits  = data[7:0];
      CFG_ROM_MASK: shadow.rom_mask     = data;
      default:      shadow.saveram_mask = data;
    endcase
    cfg_req = 1'b0;
    waited  = 0;
    do begin
      @(posedge CLK); #1;
      waited++;
    end while (cfg_ack && waited < CFG_BUDGET);
    assert (!cfg_ack) else begin
      errors++;
      $display("Config ack stayed high after the request dropped");
    end
  endtask

  task automatic run_bus_cycle(addr_t addr, logic wr_n);
    decode_t  d;
    mem_cmd_t got;
    int       req_before;
    int       done_before;
    int       waited;
    logic     mapped;
    d           = model_decode(addr, shadow);
    mapped      = d.is_rom || d.is_saveram;
    req_before  = req_count;
    done_before = done_count;
    @(posedge CLK); #1;
    bus = '{addr: addr, cs_n: 1'b1, wr_n: wr_n};  // Address settles before select
    @(posedge CLK); #1;
    bus.cs_n = 1'b0;
    if (mapped) begin
      waited = 0;
      while (done_count == done_before && waited < BUS_BUDGET - 10) begin
        @(negedge CLK);
        waited++;
      end
      assert (done_count != done_before) else begin
        errors++;
        $display("Memory transfer for address %h did not complete", addr);
      end
    end else begin
      repeat (6) @(negedge CLK);  // Room for a stray request
    end
    @(posedge CLK); #1;
    bus.cs_n = 1'b1;
    repeat (2) @(negedge CLK);
    compare("mem_req count", 24'(req_count - req_before), mapped ? 24'd1 : 24'd0);
    if (mapped && cmd_q.size() > 0) begin
      got = cmd_q.pop_front();
      compare("mem_cmd.addr", got.addr, d.mem_addr);
      compare("mem_cmd.write", got.write, !wr_n && d.is_writable);  // Save RAM only
    end
    cmd_q.delete();
  endtask

  task automatic hold_address(addr_t addr, int cycles);
    @(posedge CLK); #1;
    bus.addr = addr;
    repeat (cycles - 1) @(posedge CLK);
  endtask

  task automatic toggle_address(addr_t addr_a, addr_t addr_b, int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge CLK); #1;
      bus.addr = i[0] ? addr_b : addr_a;  // New address every edge
    end
  endtask

  //////////////////////////////////////////////////
  // Model tracking and checking
  //////////////////////////////////////////////////
  always @(posedge CLK) begin
    sel_t s;
    s = model_selects(bus.addr, shadow);  // What the decoder shows before this edge
    if (!rst_n) begin
      dspx_hist <= '0;
      msu_hist  <= '0;
    end else begin
      dspx_hist <= {dspx_hist[4:0], s.dspx};
      msu_hist  <= {msu_hist[4:0], s.msu};
    end
  end

  initial begin : decode_checker
    decode_t d;
    sel_t    s;
    forever begin
      @(negedge CLK);
      if (rst_n) begin
        d = model_decode(bus.addr, shadow);
        s = model_selects(bus.addr, shadow);
        compare("is_rom", is_rom, d.is_rom);
        compare("is_saveram", is_saveram, d.is_saveram);
        compare("dspx_sel_raw", dut.dspx_sel_raw, s.dspx);
        compare("msu_sel_raw", dut.msu_sel_raw, s.msu);
        compare("dspx_dp_enable", dspx_dp_enable, s.dp);
        compare("srtc_enable", srtc_enable, s.srtc);
        compare("dspx_a0", dspx_a0, s.a0);
        compare("dspx_enable", dspx_enable, &dspx_hist[5:2]);  // Samples 3 to 6 edges back
        compare("msu_enable", msu_enable, &msu_hist[5:2]);
      end
    end
  end

  // Memory controller with a random ack delay
  initial begin : mem_responder
    int delay;
    forever begin
      @(posedge CLK); #1;
      if (rst_n && mem_req && !mem_ack) begin
        req_count++;
        cmd_q.push_back(mem_cmd);
        delay = $urandom_range(5, 1);
        repeat (delay) begin
          @(posedge CLK); #1;
        end
        mem_ack = 1'b1;
        while (mem_req) begin
          @(posedge CLK); #1;
        end
        mem_ack = 1'b0;  // Closes the handshake
        done_count++;
      end
    end
  end

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin : main_sequence
    addr_t m;
    rst_n    = 1'b0;
    cfg_req  = 1'b0;
    cfg_sel  = CFG_MAPPER;
    cfg_data = '0;
    mem_ack  = 1'b0;
    bus      = '{addr: '0, cs_n: 1'b1, wr_n: 1'b1};
    void'($urandom(32'h2dbb));
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 rst_n = 1'b1;
    @(negedge CLK);
    compare("cfg_ack", cfg_ack, 1'b0);
    compare("mem_req", mem_req, 1'b0);
    compare("dspx_enable", dspx_enable, 1'b0);
    compare("msu_enable", msu_enable, 1'b0);
    repeat (EARLY_RUNS) run_bus_cycle(pick_address(), 1'($urandom));  // HiROM, masks zero
    foreach (map_list[i]) begin
      write_config(CFG_MAPPER, addr_t'(map_list[i]));
      write_config(CFG_FEAT, addr_t'($urandom_range(15, 0)));
      write_config(CFG_ROM_MASK, addr_t'($urandom));
      m    = addr_t'($urandom);
      m[0] = ($urandom_range(3, 0) != 0);  // Save RAM on most of the time
      write_config(CFG_SRAM_MASK, m);
      repeat (ITERS) begin
        case ($urandom_range(3, 0))
          0, 1: run_bus_cycle(pick_address(), 1'($urandom));
          2:    hold_address(pick_address(), 8);
          default: toggle_address(pick_address(), pick_address(), 8);
        endcase
      end
    end
    repeat (4) @(negedge CLK);
    $display("Checks: %0d, errors: %0d, memory transfers: %0d", checks, errors, done_count);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+verif
verilog/cart_pkg.sv
verilog/cart_config.sv
verilog/address_map.sv
verilog/select_filter.sv
verilog/mem_request.sv
verilog/cart_top.sv
verif/cart_tb.sv
